// ==== build.f ====
+incdir+rtl
rtl/cpu_decode_pkg.sv
rtl/decode_if.sv
rtl/transfer_decoder.sv
rtl/alu_op_decoder.sv
rtl/branch_decoder.sv
rtl/instruction_decoder.sv
bench/tb_clock_gen.sv
bench/instruction_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f build.f \
  --top-module instruction_decoder_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vinstruction_decoder_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
else
  echo "Pass line not found in the simulation output"
  exit 1
fi

// ==== bench/instruction_decoder_tb.sv ====
// Microcode decoder testbench
// Random opcodes, steps and flags checked against a reference model of the micro-steps
`timescale 1ns/1ps
`include "cpu_decode_consts.svh"

module instruction_decoder_tb;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 10;
  localparam int FETCH_CYCLES  = 100;
  localparam int XFER_OPS      = 40;
  localparam int ALU_OPS       = 40;
  localparam int BRANCH_OPS    = 60;
  localparam int NOP_OPS       = 10;
  // Cycles per opcode follow the step walks in the stimulus below
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 1 + FETCH_CYCLES + XFER_OPS * 7
                               + ALU_OPS * 5 + BRANCH_OPS * 4 + NOP_OPS * 30 + 2;
  localparam int WATCHDOG_NS   = (TOTAL_CYCLES + 100) * CLK_PERIOD_NS;

  // Register codes, A T B C in the order of the store and move opcodes
  localparam int R_A   = 0;
  localparam int R_T   = 1;
  localparam int R_B   = 2;
  localparam int R_C   = 3;
  localparam int R_RAM = 4;
  localparam int R_OUT = 5;

  localparam int K_NONE     = 0;
  localparam int K_DIRECT   = 1;
  localparam int K_INDIRECT = 2;
  localparam int K_SINGLE   = 3;
  localparam int K_JUMP     = 4;
  localparam int K_HALT     = 5;
  localparam int K_ALU      = 6;

  logic                        clk;
  logic                        rst_n;
  logic [`INSTR_WIDTH-1:0]     instruction;
  logic [`STEP_WIDTH-1:0]      step;
  logic                        zero;
  logic                        carry;
  logic                        odd;
  logic [`CTRL_WORD_WIDTH-1:0] control_word;
  logic [`CTRL_WORD_WIDTH-1:0] exp_q;
  logic [`INSTR_WIDTH-1:0]     exp_instr;
  logic [`STEP_WIDTH-1:0]      exp_step;

  tb_clock_gen clk_gen_i (
    .o_clk (clk)
  );

  instruction_decoder dut_i (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_instruction  (instruction),
    .i_step         (step),
    .i_zero         (zero),
    .i_carry        (carry),
    .i_odd          (odd),
    .o_control_word (control_word)
  );

  // Load order A B C mapped onto register codes
  function automatic int abc_reg(input int i);
    return (i == 0) ? R_A : i + 1;
  endfunction

  // One bus transfer, source drives and destination latches
  function automatic cpu_decode_pkg::ctrl_word_u bus_transfer_word(
    input int   src,
    input int   dst,
    input logic last
  );
    cpu_decode_pkg::ctrl_word_u w;
    w.raw      = '0;
    w.f.ro     = (src == R_RAM);
    w.f.aro    = (src == R_A);
    w.f.tro    = (src == R_T);
    w.f.bro    = (src == R_B);
    w.f.cro    = (src == R_C);
    w.f.ri     = (dst == R_RAM);
    w.f.ari    = (dst == R_A);
    w.f.tri_en = (dst == R_T);
    w.f.bri    = (dst == R_B);
    w.f.cri    = (dst == R_C);
    w.f.oi     = (dst == R_OUT);
    w.f.adv    = last;
    return w;
  endfunction

  function automatic logic [`CTRL_WORD_WIDTH-1:0] expected_word(
    input logic [`INSTR_WIDTH-1:0] instr,
    input logic [`STEP_WIDTH-1:0]  stp,
    input logic                    z,
    input logic                    c,
    input logic                    o
  );
    cpu_decode_pkg::ctrl_word_u w;
    int                         s;
    int                         kind;
    int                         idx;
    int                         src;
    int                         dst;
    int                         exec;
    logic [`ALU_OP_WIDTH-1:0]   op;
    logic                       taken;
    w.raw = '0;
    s     = int'(stp);
    kind  = K_NONE;
    src   = R_RAM;
    dst   = R_RAM;
    exec  = 2;
    op    = '0;
    taken = 1'b1;
    if (instr >= `OP_LD_A && instr <= `OP_ST_C) begin
      kind = K_DIRECT;
      idx  = int'(instr - `OP_LD_A);
      src  = (idx < 3) ? R_RAM : idx - 3;
      dst  = (idx < 3) ? abc_reg(idx) : R_RAM;
    end else if (instr >= `OP_LDT_A && instr <= `OP_STT_C) begin
      kind = K_INDIRECT;
      idx  = int'(instr - `OP_LDT_A);
      src  = (idx < 3) ? R_RAM : abc_reg(idx - 3);
      dst  = (idx < 3) ? abc_reg(idx) : R_RAM;
    end else if (instr >= `OP_MOV_AT && instr <= `OP_MOV_CB) begin
      // Three moves per source, destinations in A T B C order without the source
      kind = K_SINGLE;
      idx  = int'(instr - `OP_MOV_AT);
      src  = idx / 3;
      dst  = (idx % 3 >= src) ? idx % 3 + 1 : idx % 3;
    end else if (instr >= `OP_OUT_A && instr <= `OP_OUT_C) begin
      kind = K_SINGLE;
      src  = int'(instr - `OP_OUT_A);
      dst  = R_OUT;
    end else if (instr >= `OP_LDI_A && instr <= `OP_LDI_C) begin
      kind = K_DIRECT;
      dst  = abc_reg(int'(instr - `OP_LDI_A));
    end else if (instr >= `OP_JMP && instr <= `OP_JIO) begin
      kind  = K_JUMP;
      taken = (instr == `OP_JIZ) ? z : (instr == `OP_JIC) ? c : (instr == `OP_JIO) ? o : 1'b1;
    end else if (instr == `OP_HALT) begin
      kind = K_HALT;
    end else if (instr >= `OP_ADDI && instr <= `OP_XORI) begin
      kind = K_ALU;
      exec = 4;
      op   = `ALU_ADD + 4'(instr - `OP_ADDI);
    end else if (instr >= `OP_ADD_B && instr <= `OP_XOR_C) begin
      kind = K_ALU;
      exec = 3;
      idx  = int'(instr - `OP_ADD_B);
      src  = (idx < 5) ? R_B : R_C;
      op   = `ALU_ADD + 4'(idx % 5);
    end else if (instr >= `OP_SL && instr <= `OP_CHK) begin
      kind = K_ALU;
      op   = `ALU_SL + 4'(instr - `OP_SL);
    end

    if (s == 0) begin
      w.f.mi = 1'b1;
      w.f.co = 1'b1;
    end else if (s == 1) begin
      w.f.ro = 1'b1;
      w.f.ii = 1'b1;
      w.f.ce = 1'b1;
    end else if (kind == K_NONE) begin
      w.f.adv = (s == 2);
    end else if (kind == K_HALT) begin
      w.f.hlt = (s == 2);
    end else if (kind == K_SINGLE) begin
      if (s == 2) begin
        w = bus_transfer_word(src, dst, 1'b1);
      end
    end else if (kind == K_DIRECT || kind == K_INDIRECT) begin
      if (s == 2) begin
        w.f.mi  = 1'b1;
        w.f.co  = (kind == K_DIRECT);
        w.f.ce  = (kind == K_DIRECT);
        w.f.tro = (kind == K_INDIRECT);
      end else if (s == 3) begin
        w = bus_transfer_word(src, dst, 1'b1);
      end
    end else if (kind == K_JUMP) begin
      if (s == 2) begin
        w.f.mi  = 1'b1;
        w.f.co  = 1'b1;
        w.f.ce  = 1'b1;
        w.f.adv = ~taken;
      end else if (s == 3) begin
        w.f.ro  = 1'b1;
        w.f.j   = 1'b1;
        w.f.adv = 1'b1;
      end
    end else if (s == exec) begin
      w.f.eo     = 1'b1;
      w.f.tri_en = 1'b1;
      w.f.el     = 1'b1;
      w.f.adv    = 1'b1;
      w.f.alu_op = op;
    end else if (exec == 4 && s == 2) begin
      w.f.mi = 1'b1;
      w.f.co = 1'b1;
      w.f.ce = 1'b1;
    end else if (exec > 2 && s == exec - 1) begin
      // Operand into T, from RAM for immediates and from B or C otherwise
      w = bus_transfer_word(src, R_T, 1'b0);
    end
    return w.raw;
  endfunction

  // Model of the output register, fed with the values the DUT samples
  always @(posedge clk) begin
    exp_q     <= rst_n ? expected_word(instruction, step, zero, carry, odd) : '0;
    exp_instr <= instruction;
    exp_step  <= step;
  end

  always @(negedge clk) begin
    assert (control_word === exp_q) else begin
      $display("error: o_control_word expected 0x%06h actual 0x%06h (instr 0x%04h step %0d)",
               exp_q, control_word, exp_instr, exp_step);
      $display("Regression failed");
      $fatal(1, "control word mismatch");
    end
  end

  task automatic drive_decode(input logic [`INSTR_WIDTH-1:0] instr,
                              input logic [`STEP_WIDTH-1:0] stp);
    logic [31:0] r;
    @(posedge clk);
    r = $urandom;
    instruction <= instr;
    step        <= stp;
    zero        <= r[0];
    carry       <= r[1];
    odd         <= r[2];
  endtask

  task automatic walk_steps(input logic [`INSTR_WIDTH-1:0] instr, input int first,
                            input int last);
    int s;
    for (s = first; s <= last; s++) begin
      drive_decode(instr, 5'(s));
    end
  endtask

  task automatic expect_cleared(input string when);
    @(negedge clk);
    assert (control_word == '0) else begin
      $display("error: o_control_word expected 0x000000 actual 0x%06h %s", control_word, when);
      $display("Regression failed");
      $fatal(1, "control word not cleared");
    end
  endtask

  initial begin : stimulus
    int                      n;
    int                      r;
    logic [`INSTR_WIDTH-1:0] op;
    void'($urandom(2));
    rst_n       = 1'b0;
    instruction = '0;
    step        = '0;
    zero        = 1'b0;
    carry       = 1'b0;
    odd         = 1'b0;

    for (n = 0; n < RESET_CYCLES; n++) begin
      drive_decode(16'($urandom), 5'($urandom));
      expect_cleared("during reset");
    end
    drive_decode(16'($urandom), 5'($urandom));
    rst_n <= 1'b1;
    expect_cleared("on the first cycle after reset");

    for (n = 0; n < FETCH_CYCLES; n++) begin
      drive_decode(16'($urandom), 5'($urandom % 2));
    end

    // Transfer opcodes sit in 0x01 to 0x19 and 0x26 to 0x2c
    for (n = 0; n < XFER_OPS; n++) begin
      r  = int'($urandom % 32);
      op = (r < 25) ? 16'(`OP_LD_A + r) : 16'(`OP_OUT_A + r - 25);
      walk_steps(op, 0, 5);
      drive_decode(op, 5'(6 + $urandom % 26));
    end

    for (n = 0; n < ALU_OPS; n++) begin
      op = 16'(`OP_ADDI + $urandom % 26);
      walk_steps(op, 2, 5);
      drive_decode(op, 5'(6 + $urandom % 26));
    end

    for (n = 0; n < BRANCH_OPS; n++) begin
      r  = int'($urandom % 5);
      op = (r == 4) ? `OP_HALT : 16'(`OP_JMP + r);
      walk_steps(op, 2, 5);
    end

    // Unused opcodes, the old stack range 0x1a to 0x25, 0x4b to 0xfffe and zero
    for (n = 0; n < NOP_OPS; n++) begin
      r = int'($urandom % 3);
      if (r == 0) begin
        op = 16'(16'h001a + $urandom % 12);
      end else if (r == 1) begin
        op = 16'(16'h004b + $urandom % 32'h0000_ffb4);
      end else begin
        op = 16'h0000;
      end
      walk_steps(op, 2, 31);
    end

    // Let the last decode reach the output and be checked
    @(posedge clk);
    @(negedge clk);
    @(posedge clk);
    $display("Regression passed");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the decode sequence did not finish within %0d ns", WATCHDOG_NS);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock source
// Free-running clock with an 8 ns period
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk
);

  // Half of the 8 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #4 o_clk = ~o_clk;
    end
  end

endmodule

// ==== rtl/instruction_decoder.sv ====
// Microcode decoder top level
// Fetch steps, group decoder merge, NOP fallback and the registered control word
`timescale 1ns/1ps
`include "cpu_decode_consts.svh"

module instruction_decoder (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [`INSTR_WIDTH-1:0]     i_instruction,
  input  logic [`STEP_WIDTH-1:0]      i_step,
  input  logic                        i_zero,
  input  logic                        i_carry,
  input  logic                        i_odd,
  output logic [`CTRL_WORD_WIDTH-1:0] o_control_word
);

  cpu_decode_pkg::ctrl_word_u  xfer_word;
  cpu_decode_pkg::ctrl_word_u  alu_word;
  cpu_decode_pkg::ctrl_word_u  br_word;
  cpu_decode_pkg::ctrl_word_u  next_word;
  logic                        xfer_claim;
  logic                        alu_claim;
  logic                        br_claim;
  logic [`CTRL_WORD_WIDTH-1:0] ctrl_q;

  decode_if dec_bus ();

  assign dec_bus.instr = i_instruction;
  assign dec_bus.step  = i_step;
  assign dec_bus.zero  = i_zero;
  assign dec_bus.carry = i_carry;
  assign dec_bus.odd   = i_odd;

  transfer_decoder xfer_i (
    .bus     (dec_bus.sink),
    .o_claim (xfer_claim),
    .o_word  (xfer_word)
  );

  alu_op_decoder alu_i (
    .bus     (dec_bus.sink),
    .o_claim (alu_claim),
    .o_word  (alu_word)
  );

  branch_decoder br_i (
    .bus     (dec_bus.sink),
    .o_claim (br_claim),
    .o_word  (br_word)
  );

  always_comb begin
    next_word.raw = '0;
    case (i_step)
      // Every instruction starts by loading the opcode from PC and bumping PC
      `STEP_WIDTH'(0): begin
        next_word.f.mi = 1'b1;
        next_word.f.co = 1'b1;
      end
      `STEP_WIDTH'(1): begin
        next_word.f.ro = 1'b1;
        next_word.f.ii = 1'b1;
        next_word.f.ce = 1'b1;
      end
      default: begin
        // Groups are disjoint and an idle group drives zero, so OR is enough
        if (xfer_claim || alu_claim || br_claim) begin
          next_word.raw = xfer_word.raw | alu_word.raw | br_word.raw;
        end else if (i_step == `STEP_WIDTH'(2)) begin
          next_word.f.adv = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= next_word.raw;
    end
  end

  assign o_control_word = ctrl_q;

endmodule

// ==== rtl/branch_decoder.sv ====
// Branch group decoder
// Micro-steps for JMP, the flag-conditional jumps and HALT
`timescale 1ns/1ps
`include "cpu_decode_consts.svh"

module branch_decoder (
  decode_if.sink                     bus,
  output logic                       o_claim,
  output cpu_decode_pkg::ctrl_word_u o_word
);

  logic is_jump;
  logic is_halt;
  logic take;

  assign is_jump = bus.instr inside {[`OP_JMP:`OP_JIO]};
  assign is_halt = (bus.instr == `OP_HALT);
  assign o_claim = is_jump | is_halt;

  // JMP is treated as a jump whose condition always holds
  always_comb begin
    case (bus.instr)
      `OP_JIZ: take = bus.zero;
      `OP_JIC: take = bus.carry;
      `OP_JIO: take = bus.odd;
      default: take = 1'b1;
    endcase
  end

  always_comb begin
    o_word.raw = '0;
    case (bus.step)
      `STEP_WIDTH'(2): begin
        if (is_jump) begin
          o_word.f.mi  = 1'b1;
          o_word.f.co  = 1'b1;
          o_word.f.ce  = 1'b1;
          // A failed test ends here with the address word already skipped
          o_word.f.adv = ~take;
        end else if (is_halt) begin
          o_word.f.hlt = 1'b1;
        end
      end
      `STEP_WIDTH'(3): begin
        if (is_jump) begin
          o_word.f.ro  = 1'b1;
          o_word.f.j   = 1'b1;
          o_word.f.adv = 1'b1;
        end
      end
      default: o_word.raw = '0;
    endcase
  end

endmodule

// ==== rtl/alu_op_decoder.sv ====
// ALU group decoder
// Micro-steps for immediate, register and unary ALU instructions
`timescale 1ns/1ps
`include "cpu_decode_consts.svh"

module alu_op_decoder (
  decode_if.sink                     bus,
  output logic                       o_claim,
  output cpu_decode_pkg::ctrl_word_u o_word
);

  logic                       is_imm;
  logic                       is_reg_b;
  logic                       is_reg_c;
  logic                       is_unary;
  logic [`ALU_OP_WIDTH-1:0]   op;
  logic [`STEP_WIDTH-1:0]     exec_step;
  cpu_decode_pkg::ctrl_word_u exec_word;

  assign is_imm   = bus.instr inside {[`OP_ADDI:`OP_XORI]};
  assign is_reg_b = bus.instr inside {[`OP_ADD_B:`OP_XOR_B]};
  assign is_reg_c = bus.instr inside {[`OP_ADD_C:`OP_XOR_C]};
  assign is_unary = bus.instr inside {[`OP_SL:`OP_CHK]};
  assign o_claim  = is_imm | is_reg_b | is_reg_c | is_unary;

  always_comb begin
    case (bus.instr)
      `OP_ADDI, `OP_ADD_B, `OP_ADD_C: op = `ALU_ADD;
      `OP_SUBI, `OP_SUB_B, `OP_SUB_C: op = `ALU_SUB;
      `OP_ANDI, `OP_AND_B, `OP_AND_C: op = `ALU_AND;
      `OP_ORI,  `OP_OR_B,  `OP_OR_C:  op = `ALU_OR;
      `OP_XORI, `OP_XOR_B, `OP_XOR_C: op = `ALU_XOR;
      `OP_SL:   op = `ALU_SL;
      `OP_SR:   op = `ALU_SR;
      `OP_ASR:  op = `ALU_ASR;
      `OP_ROL:  op = `ALU_ROL;
      `OP_ROR:  op = `ALU_ROR;
      `OP_ROLC: op = `ALU_ROLC;
      `OP_RORC: op = `ALU_RORC;
      `OP_INV:  op = `ALU_INV;
      `OP_NEG:  op = `ALU_NEG;
      `OP_ABS:  op = `ALU_ABS;
      `OP_CHK:  op = `ALU_CHK;
      default:  op = `ALU_ADD;
    endcase
  end

  // The ALU result always lands in T and updates the flags on the last step
  assign exec_step = is_imm ? `STEP_WIDTH'(4) :
                     (is_reg_b || is_reg_c) ? `STEP_WIDTH'(3) : `STEP_WIDTH'(2);

  always_comb begin
    exec_word.raw      = '0;
    exec_word.f.eo     = 1'b1;
    exec_word.f.tri_en = 1'b1;
    exec_word.f.el     = 1'b1;
    exec_word.f.adv    = 1'b1;
    exec_word.f.alu_op = op;
  end

  always_comb begin
    o_word.raw = '0;
    if (o_claim && bus.step == exec_step) begin
      o_word = exec_word;
    end else if (is_imm && bus.step == `STEP_WIDTH'(2)) begin
      o_word.f.mi = 1'b1;
      o_word.f.co = 1'b1;
      o_word.f.ce = 1'b1;
    end else if (is_imm && bus.step == `STEP_WIDTH'(3)) begin
      // Immediate operand goes through T before the ALU sees it
      o_word.f.ro     = 1'b1;
      o_word.f.tri_en = 1'b1;
    end else if ((is_reg_b || is_reg_c) && bus.step == `STEP_WIDTH'(2)) begin
      o_word.f.bro    = is_reg_b;
      o_word.f.cro    = is_reg_c;
      o_word.f.tri_en = 1'b1;
    end
  end

endmodule

// ==== rtl/transfer_decoder.sv ====
// Transfer group decoder
// Micro-steps for loads, stores, immediates, register moves and OUT
`timescale 1ns/1ps
`include "cpu_decode_consts.svh"

module transfer_decoder (
  decode_if.sink                     bus,
  output logic                       o_claim,
  output cpu_decode_pkg::ctrl_word_u o_word
);

  cpu_decode_pkg::ctrl_word_u path;
  logic                       mem_direct;
  logic                       mem_indirect;
  logic                       single_step;

  // Address comes from the word after the opcode
  assign mem_direct   = bus.instr inside {[`OP_LD_A:`OP_ST_C], [`OP_LDI_A:`OP_LDI_C]};
  // Address comes from T
  assign mem_indirect = bus.instr inside {[`OP_LDT_A:`OP_STT_C]};
  assign single_step  = bus.instr inside {[`OP_MOV_AT:`OP_MOV_CB], [`OP_OUT_A:`OP_OUT_C]};
  assign o_claim      = mem_direct | mem_indirect | single_step;

  // Source and destination of the data move, used on the last step of every form
  always_comb begin
    path.raw      = '0;
    path.f.aro    = bus.instr inside {`OP_ST_A, `OP_STT_A, `OP_MOV_AT, `OP_MOV_AB,
                                      `OP_MOV_AC, `OP_OUT_A};
    path.f.tro    = bus.instr inside {`OP_ST_T, `OP_MOV_TA, `OP_MOV_TB, `OP_MOV_TC,
                                      `OP_OUT_T};
    path.f.bro    = bus.instr inside {`OP_ST_B, `OP_STT_B, `OP_MOV_BA, `OP_MOV_BT,
                                      `OP_MOV_BC, `OP_OUT_B};
    path.f.cro    = bus.instr inside {`OP_ST_C, `OP_STT_C, `OP_MOV_CA, `OP_MOV_CT,
                                      `OP_MOV_CB, `OP_OUT_C};
    path.f.ari    = bus.instr inside {`OP_LD_A, `OP_LDT_A, `OP_LDI_A, `OP_MOV_TA,
                                      `OP_MOV_BA, `OP_MOV_CA};
    path.f.bri    = bus.instr inside {`OP_LD_B, `OP_LDT_B, `OP_LDI_B, `OP_MOV_AB,
                                      `OP_MOV_TB, `OP_MOV_CB};
    path.f.cri    = bus.instr inside {`OP_LD_C, `OP_LDT_C, `OP_LDI_C, `OP_MOV_AC,
                                      `OP_MOV_TC, `OP_MOV_BC};
    path.f.tri_en = bus.instr inside {`OP_MOV_AT, `OP_MOV_BT, `OP_MOV_CT};
    // RAM is the source for every load and the sink for every store
    path.f.ro     = bus.instr inside {[`OP_LD_A:`OP_LD_C], [`OP_LDT_A:`OP_LDT_C],
                                      [`OP_LDI_A:`OP_LDI_C]};
    path.f.ri     = bus.instr inside {[`OP_ST_A:`OP_ST_C], [`OP_STT_A:`OP_STT_C]};
    path.f.oi     = bus.instr inside {[`OP_OUT_A:`OP_OUT_C]};
  end

  always_comb begin
    o_word.raw = '0;
    case (bus.step)
      `STEP_WIDTH'(2): begin
        if (mem_direct) begin
          // Point MAR at the operand word and step past it
          o_word.f.mi = 1'b1;
          o_word.f.co = 1'b1;
          o_word.f.ce = 1'b1;
        end else if (mem_indirect) begin
          o_word.f.mi  = 1'b1;
          o_word.f.tro = 1'b1;
        end else if (single_step) begin
          o_word.raw   = path.raw;
          o_word.f.adv = 1'b1;
        end
      end
      `STEP_WIDTH'(3): begin
        if (mem_direct || mem_indirect) begin
          o_word.raw   = path.raw;
          o_word.f.adv = 1'b1;
        end
      end
      default: o_word.raw = '0;
    endcase
  end

endmodule

// ==== rtl/decode_if.sv ====
// Decode bus from the top level to the group decoders
`timescale 1ns/1ps
`include "cpu_decode_consts.svh"

interface decode_if;
  logic [`INSTR_WIDTH-1:0] instr;
  logic [`STEP_WIDTH-1:0]  step;
  logic                    zero;
  logic                    carry;
  logic                    odd;

  // Top level drives, group decoders listen
  modport source (
    output instr, step, zero, carry, odd
  );

  modport sink (
    input instr, step, zero, carry, odd
  );
endinterface

// ==== rtl/cpu_decode_pkg.sv ====
// CPU decode types
// Control word field layout and its flat/field union
`include "cpu_decode_consts.svh"

package cpu_decode_pkg;

  // Fields run from the MSB down and alu_op sits in the low nibble
  typedef struct packed {
    // Bus output enables
    logic                     co;
    logic                     ro;
    logic                     aro;
    logic                     bro;
    logic                     cro;
    logic                     tro;
    logic                     eo;
    // Load enables for MAR, IR, RAM, A, B, C, T, output and PC
    logic                     mi;
    logic                     ii;
    logic                     ri;
    logic                     ari;
    logic                     bri;
    logic                     cri;
    logic                     tri_en;
    logic                     oi;
    logic                     j;
    // Single control lines
    logic                     ce;
    logic                     el;
    logic                     adv;
    logic                     hlt;
    logic [`ALU_OP_WIDTH-1:0] alu_op;
  } ctrl_fields_t;

  typedef union packed {
    logic [`CTRL_WORD_WIDTH-1:0] raw;
    ctrl_fields_t                f;
  } ctrl_word_u;

endpackage

// ==== rtl/cpu_decode_consts.svh ====
// CPU decode constants
// Instruction, step and control word widths, ALU operation codes and opcodes
`ifndef CPU_DECODE_CONSTS_SVH
`define CPU_DECODE_CONSTS_SVH

`define INSTR_WIDTH      16
`define STEP_WIDTH       5
`define CTRL_WORD_WIDTH  24
`define ALU_OP_WIDTH     4

// ALU operation select, driven on the alu_op field during EO
`define ALU_ADD   4'h0
`define ALU_SUB   4'h1
`define ALU_AND   4'h2
`define ALU_OR    4'h3
`define ALU_XOR   4'h4
`define ALU_SL    4'h5
`define ALU_SR    4'h6
`define ALU_ASR   4'h7
`define ALU_ROL   4'h8
`define ALU_ROR   4'h9
`define ALU_ROLC  4'ha
`define ALU_RORC  4'hb
`define ALU_INV   4'hc
`define ALU_NEG   4'hd
`define ALU_ABS   4'he
`define ALU_CHK   4'hf

// Memory loads and stores, address in the next word
`define OP_LD_A   16'h0001
`define OP_LD_B   16'h0002
`define OP_LD_C   16'h0003
`define OP_ST_A   16'h0004
`define OP_ST_T   16'h0005
`define OP_ST_B   16'h0006
`define OP_ST_C   16'h0007

// Loads and stores with the address held in T
`define OP_LDT_A  16'h0008
`define OP_LDT_B  16'h0009
`define OP_LDT_C  16'h000a
`define OP_STT_A  16'h000b
`define OP_STT_B  16'h000c
`define OP_STT_C  16'h000d

// Register moves, source first
`define OP_MOV_AT 16'h000e
`define OP_MOV_AB 16'h000f
`define OP_MOV_AC 16'h0010
`define OP_MOV_TA 16'h0011
`define OP_MOV_TB 16'h0012
`define OP_MOV_TC 16'h0013
`define OP_MOV_BA 16'h0014
`define OP_MOV_BT 16'h0015
`define OP_MOV_BC 16'h0016
`define OP_MOV_CA 16'h0017
`define OP_MOV_CT 16'h0018
`define OP_MOV_CB 16'h0019

`define OP_OUT_A  16'h0026
`define OP_OUT_T  16'h0027
`define OP_OUT_B  16'h0028
`define OP_OUT_C  16'h0029

`define OP_LDI_A  16'h002a
`define OP_LDI_B  16'h002b
`define OP_LDI_C  16'h002c

`define OP_JMP    16'h002d
`define OP_JIZ    16'h002e
`define OP_JIC    16'h002f
`define OP_JIO    16'h0030

// ALU with an immediate operand
`define OP_ADDI   16'h0031
`define OP_SUBI   16'h0032
`define OP_ANDI   16'h0033
`define OP_ORI    16'h0034
`define OP_XORI   16'h0035

// ALU with B or C as the second operand
`define OP_ADD_B  16'h0036
`define OP_SUB_B  16'h0037
`define OP_AND_B  16'h0038
`define OP_OR_B   16'h0039
`define OP_XOR_B  16'h003a
`define OP_ADD_C  16'h003b
`define OP_SUB_C  16'h003c
`define OP_AND_C  16'h003d
`define OP_OR_C   16'h003e
`define OP_XOR_C  16'h003f

// Unary operations on A, result in T
`define OP_SL     16'h0040
`define OP_SR     16'h0041
`define OP_ASR    16'h0042
`define OP_ROL    16'h0043
`define OP_ROR    16'h0044
`define OP_ROLC   16'h0045
`define OP_RORC   16'h0046
`define OP_INV    16'h0047
`define OP_NEG    16'h0048
`define OP_ABS    16'h0049
`define OP_CHK    16'h004a

`define OP_HALT   16'hffff

`endif
